//--- hw/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
        input  rv_pkg::ex_ctrl_t ex_ctrl,
        output rv_pkg::result_t  ex_res
);
        import rv_pkg::*;

        word_t    alu_out;
        logic     cond;
        logic [4:0] shamt;
        word_t    next_pc;

        assign shamt = ex_ctrl.op_b[4:0];

        // ========================================================
        // ALU
        always_comb begin
                case (ex_ctrl.alu_op)
                        ALU_ADD:    alu_out = ex_ctrl.op_a + ex_ctrl.op_b;
                        ALU_SUB:    alu_out = ex_ctrl.op_a - ex_ctrl.op_b;
                        ALU_SLT:    alu_out = {31'b0, $signed(ex_ctrl.op_a) < $signed(ex_ctrl.op_b)};
                        ALU_SLTU:   alu_out = {31'b0, ex_ctrl.op_a < ex_ctrl.op_b};
                        ALU_XOR:    alu_out = ex_ctrl.op_a ^ ex_ctrl.op_b;
                        ALU_OR:     alu_out = ex_ctrl.op_a | ex_ctrl.op_b;
                        ALU_AND:    alu_out = ex_ctrl.op_a & ex_ctrl.op_b;
                        ALU_SLL:    alu_out = ex_ctrl.op_a << shamt;
                        ALU_SRL:    alu_out = ex_ctrl.op_a >> shamt;
                        ALU_SRA:    alu_out = word_t'($signed(ex_ctrl.op_a) >>> shamt);
                        ALU_PASS_B: alu_out = ex_ctrl.op_b;
                        default:    alu_out = '0;
                endcase
        end

        // ========================================================
        // branch comparator
        always_comb begin
                case (ex_ctrl.br_cond)
                        BR_EQ:   cond = (ex_ctrl.op_a == ex_ctrl.op_b);
                        BR_NE:   cond = (ex_ctrl.op_a != ex_ctrl.op_b);
                        BR_LT:   cond = ($signed(ex_ctrl.op_a) < $signed(ex_ctrl.op_b));
                        BR_GE:   cond = ($signed(ex_ctrl.op_a) >= $signed(ex_ctrl.op_b));
                        BR_LTU:  cond = (ex_ctrl.op_a < ex_ctrl.op_b);
                        BR_GEU:  cond = (ex_ctrl.op_a >= ex_ctrl.op_b);
                        default: cond = 1'b0;
                endcase
        end

        assign next_pc = cond ? ex_ctrl.pc + ex_ctrl.branch_offset : ex_ctrl.pc + 32'd4;

        always_comb begin
                ex_res.pc = ex_ctrl.pc;
                ex_res.rd = ex_ctrl.rd;
                ex_res.write_rd = ex_ctrl.write_rd;
                ex_res.taken = ex_ctrl.is_branch && cond;
                ex_res.illegal = ex_ctrl.illegal;
                // illegal slots report a zero value
                if (ex_ctrl.illegal)
                        ex_res.value = '0;
                else if (ex_ctrl.is_branch)
                        ex_res.value = next_pc;
                else
                        ex_res.value = alu_out;
        end

endmodule

//--- hw/alu_pipe_top.sv
`timescale 1ns/1ns

module alu_pipe_top (
        input  logic               clk,
        input  logic               reset,
        input  logic               in_req,
        input  rv_pkg::fetch_pkt_t in_pkt,
        output logic               in_ack,
        output logic               res_req,
        output rv_pkg::result_t    res,
        input  logic               res_ack
);
        import rv_pkg::*;

        ex_ctrl_t dec_ctrl;
        ex_ctrl_t ex_ctrl;
        result_t  ex_res;
        logic     dec_load;
        logic     ex_free;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        word_t    rs1_data;
        word_t    rs2_data;

        inst_decode i_decode (
                .clk      (clk),
                .reset    (reset),
                .in_req   (in_req),
                .in_pkt   (in_pkt),
                .in_ack   (in_ack),
                .ex_ctrl  (ex_ctrl),
                .ex_free  (ex_free),
                .rs1_idx  (rs1_idx),
                .rs2_idx  (rs2_idx),
                .rs1_data (rs1_data),
                .rs2_data (rs2_data),
                .dec_ctrl (dec_ctrl),
                .dec_load (dec_load)
        );

        id_ex_reg i_id_ex (
                .clk      (clk),
                .reset    (reset),
                .dec_load (dec_load),
                .dec_ctrl (dec_ctrl),
                .ex_free  (ex_free),
                .ex_taken (ex_res.taken),
                .ex_ctrl  (ex_ctrl)
        );

        alu_execute i_execute (
                .ex_ctrl (ex_ctrl),
                .ex_res  (ex_res)
        );

        result_writeback i_writeback (
                .clk           (clk),
                .reset         (reset),
                .ex_ctrl_valid (ex_ctrl.valid),
                .ex_res        (ex_res),
                .ex_free       (ex_free),
                .rs1_idx       (rs1_idx),
                .rs2_idx       (rs2_idx),
                .rs1_data      (rs1_data),
                .rs2_data      (rs2_data),
                .res_req       (res_req),
                .res           (res),
                .res_ack       (res_ack)
        );

endmodule

//--- hw/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
        input  logic             clk,
        input  logic             reset,
        input  logic             dec_load,
        input  rv_pkg::ex_ctrl_t dec_ctrl,
        input  logic             ex_free,
        input  logic             ex_taken,
        output rv_pkg::ex_ctrl_t ex_ctrl
);
        import rv_pkg::*;

        logic leave;
        logic squash_next;
        logic squash_now;

        // occupant moves on to the result stage this edge
        assign leave = ex_ctrl.valid && ex_free;

        // a taken branch leaving now squashes a load on the same edge
        assign squash_now = squash_next || (leave && ex_taken);

        always_ff @(posedge clk) begin
                if (reset) begin
                        ex_ctrl.valid <= 1'b0;
                        squash_next <= 1'b0;
                end else begin
                        if (dec_load) begin
                                ex_ctrl <= dec_ctrl;
                                ex_ctrl.valid <= dec_ctrl.valid && !squash_now;
                        end else if (leave) begin
                                ex_ctrl.valid <= 1'b0;
                        end

                        if (dec_load)
                                squash_next <= 1'b0;
                        else if (leave && ex_taken)
                                squash_next <= 1'b1;
                end
        end

endmodule

//--- hw/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
        input  logic              clk,
        input  logic              reset,
        input  logic              in_req,
        input  rv_pkg::fetch_pkt_t in_pkt,
        output logic              in_ack,
        input  rv_pkg::ex_ctrl_t  ex_ctrl,
        input  logic              ex_free,
        output rv_pkg::reg_idx_t  rs1_idx,
        output rv_pkg::reg_idx_t  rs2_idx,
        input  rv_pkg::word_t     rs1_data,
        input  rv_pkg::word_t     rs2_data,
        output rv_pkg::ex_ctrl_t  dec_ctrl,
        output logic              dec_load
);
        import rv_pkg::*;

        hs_state_e state;
        logic      in_req_q;
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        reg_idx_t  rd_f;
        word_t     imm_i;
        word_t     imm_u;
        word_t     imm_b;
        logic      stage_free;
        logic      hazard;

        function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt_sub,
                                            input logic alt_sra);
                case (f3)
                        3'b000: alu_sel = alt_sub ? ALU_SUB : ALU_ADD;
                        3'b001: alu_sel = ALU_SLL;
                        3'b010: alu_sel = ALU_SLT;
                        3'b011: alu_sel = ALU_SLTU;
                        3'b100: alu_sel = ALU_XOR;
                        3'b101: alu_sel = alt_sra ? ALU_SRA : ALU_SRL;
                        3'b110: alu_sel = ALU_OR;
                        default: alu_sel = ALU_AND;
                endcase
        endfunction

        // ========================================================
        // field slicing and immediates
        assign opcode  = in_pkt.instr[6:0];
        assign rd_f    = in_pkt.instr[11:7];
        assign funct3  = in_pkt.instr[14:12];
        assign funct7  = in_pkt.instr[31:25];
        assign rs1_idx = in_pkt.instr[19:15];
        assign rs2_idx = in_pkt.instr[24:20];

        assign imm_i = {{20{in_pkt.instr[31]}}, in_pkt.instr[31:20]};
        assign imm_u = {in_pkt.instr[31:12], 12'b0};
        assign imm_b = {{19{in_pkt.instr[31]}}, in_pkt.instr[31], in_pkt.instr[7],
                        in_pkt.instr[30:25], in_pkt.instr[11:8], 1'b0};

        always_comb begin
                dec_ctrl = '0;
                dec_ctrl.valid = 1'b1;
                dec_ctrl.pc = in_pkt.pc;
                dec_ctrl.op_a = rs1_data;
                dec_ctrl.op_b = rs2_data;
                dec_ctrl.alu_op = ALU_ADD;
                dec_ctrl.br_cond = funct3;
                dec_ctrl.branch_offset = imm_b;
                case (opcode)
                        OPC_LUI: begin
                                dec_ctrl.op_b = imm_u;
                                dec_ctrl.alu_op = ALU_PASS_B;
                                dec_ctrl.write_rd = 1'b1;
                        end
                        OPC_AUIPC: begin
                                dec_ctrl.op_a = in_pkt.pc;
                                dec_ctrl.op_b = imm_u;
                                dec_ctrl.write_rd = 1'b1;
                        end
                        OPC_OP: begin
                                dec_ctrl.alu_op = alu_sel(funct3, funct7[5], funct7[5]);
                                dec_ctrl.write_rd = 1'b1;
                        end
                        OPC_OP_IMM: begin
                                // bit 30 selects sra only, addi has no subtract form
                                dec_ctrl.op_b = imm_i;
                                dec_ctrl.alu_op = alu_sel(funct3, 1'b0, funct7[5]);
                                dec_ctrl.write_rd = 1'b1;
                        end
                        OPC_BRANCH: begin
                                // funct3 010 and 011 are not branches
                                dec_ctrl.is_branch = (funct3[2:1] != 2'b01);
                                dec_ctrl.illegal = (funct3[2:1] == 2'b01);
                        end
                        default: dec_ctrl.illegal = 1'b1;
                endcase
                dec_ctrl.rd = dec_ctrl.write_rd ? rd_f : '0;
        end

        // ========================================================
        // read-after-write stall against the id_ex occupant
        assign hazard = ex_ctrl.valid && ex_ctrl.write_rd && (ex_ctrl.rd != '0) &&
                        ((ex_ctrl.rd == rs1_idx) || (ex_ctrl.rd == rs2_idx));

        assign stage_free = !ex_ctrl.valid || ex_free;

        // req must be seen on an edge before the item is taken
        assign dec_load = (state == IDLE) && in_req && in_req_q && stage_free && !hazard;
        assign in_ack = (state == ACK_HIGH);

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= IDLE;
                        in_req_q <= 1'b0;
                end else begin
                        in_req_q <= in_req;
                        case (state)
                                IDLE:     if (dec_load) state <= ACK_HIGH;
                                ACK_HIGH: if (!in_req) state <= IDLE;
                                default:  state <= IDLE;
                        endcase
                end
        end

endmodule

//--- hw/result_writeback.sv
`timescale 1ns/1ns

module result_writeback (
        input  logic             clk,
        input  logic             reset,
        input  logic             ex_ctrl_valid,
        input  rv_pkg::result_t  ex_res,
        output logic             ex_free,
        input  rv_pkg::reg_idx_t rs1_idx,
        input  rv_pkg::reg_idx_t rs2_idx,
        output rv_pkg::word_t    rs1_data,
        output rv_pkg::word_t    rs2_data,
        output logic             res_req,
        output rv_pkg::result_t  res,
        input  logic             res_ack
);
        import rv_pkg::*;

        hs_state_e state;
        logic      capture;
        word_t     regs [1:31];

        assign ex_free = (state == IDLE);
        assign capture = ex_ctrl_valid && ex_free;
        assign res_req = (state == ACK_HIGH);

        // ========================================================
        // output handshake
        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= IDLE;
                end else begin
                        case (state)
                                IDLE:     if (capture) state <= ACK_HIGH;
                                ACK_HIGH: if (res_ack) state <= WAIT_LOW;
                                WAIT_LOW: if (!res_ack) state <= IDLE;
                                default:  state <= IDLE;
                        endcase
                end
        end

        // held stable while res_req is up
        always_ff @(posedge clk) begin
                if (capture)
                        res <= ex_res;
        end

        // ========================================================
        // register file, write lands on the capture edge
        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 1; i < 32; i++)
                                regs[i] <= '0;
                end else if (capture && ex_res.write_rd && (ex_res.rd != '0)) begin
                        regs[ex_res.rd] <= ex_res.value;
                end
        end

        // x0 is hardwired
        assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
        assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- hw/rv_pkg.sv
package rv_pkg;

        localparam int XLEN = 32;
        localparam int REG_IDX_W = 5;

        typedef logic [XLEN-1:0] word_t;
        typedef logic [REG_IDX_W-1:0] reg_idx_t;
        typedef logic [3:0] alu_op_t;
        typedef logic [2:0] br_cond_t;

        // major opcodes handled by this half of the pipe
        localparam logic [6:0] OPC_LUI    = 7'b0110111;
        localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
        localparam logic [6:0] OPC_OP     = 7'b0110011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_BRANCH = 7'b1100011;

        localparam alu_op_t ALU_ADD    = 4'd0;
        localparam alu_op_t ALU_SUB    = 4'd1;
        localparam alu_op_t ALU_SLT    = 4'd2;
        localparam alu_op_t ALU_SLTU   = 4'd3;
        localparam alu_op_t ALU_XOR    = 4'd4;
        localparam alu_op_t ALU_OR     = 4'd5;
        localparam alu_op_t ALU_AND    = 4'd6;
        localparam alu_op_t ALU_SLL    = 4'd7;
        localparam alu_op_t ALU_SRL    = 4'd8;
        localparam alu_op_t ALU_SRA    = 4'd9;
        localparam alu_op_t ALU_PASS_B = 4'd10;

        // branch funct3 encodings
        localparam br_cond_t BR_EQ  = 3'b000;
        localparam br_cond_t BR_NE  = 3'b001;
        localparam br_cond_t BR_LT  = 3'b100;
        localparam br_cond_t BR_GE  = 3'b101;
        localparam br_cond_t BR_LTU = 3'b110;
        localparam br_cond_t BR_GEU = 3'b111;

        typedef struct packed {
                word_t pc;
                word_t instr;
        } fetch_pkt_t;

        typedef struct packed {
                logic     valid;
                word_t    pc;
                reg_idx_t rd;
                word_t    op_a;
                word_t    op_b;
                alu_op_t  alu_op;
                logic     is_branch;
                br_cond_t br_cond;
                word_t    branch_offset;
                logic     write_rd;
                logic     illegal;
        } ex_ctrl_t;

        typedef struct packed {
                word_t    pc;
                reg_idx_t rd;
                word_t    value;
                logic     write_rd;
                logic     taken;
                logic     illegal;
        } result_t;

        // phases of a four-phase req/ack exchange
        typedef enum logic [1:0] {
                IDLE,
                ACK_HIGH,
                WAIT_LOW
        } hs_state_e;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_alu_pipe

# the simulation may stop early on an assertion, so its status is not trusted alone
out=$(./obj_dir/Vtb_alu_pipe 2>&1) || true
echo "$out"

if grep -qxF '>>> PASS' <<< "$out"; then
        exit 0
else
        exit 1
fi

//--- testbench/alu_pipe_assertions.sv
`timescale 1ns/1ns

module alu_pipe_assertions (
        input logic            clk,
        input logic            reset,
        input logic            in_req,
        input logic            in_ack,
        input logic            res_req,
        input rv_pkg::result_t res,
        input logic            res_ack
);

        // ack only answers a pending request
        ack_needs_req: assert property (@(posedge clk) disable iff (reset)
                $rose(in_ack) |-> $past(in_req))
                else $error("in_ack rose while in_req was low");

        // result held until the sink answers
        req_held: assert property (@(posedge clk) disable iff (reset)
                (res_req && !res_ack) |=> (res_req && $stable(res)))
                else $error("res_req dropped or res changed before res_ack");

        no_req_under_ack: assert property (@(posedge clk) disable iff (reset)
                $rose(res_req) |-> !$past(res_ack))
                else $error("res_req rose while res_ack was still high");

endmodule

bind alu_pipe_top alu_pipe_assertions i_assertions (
        .clk     (clk),
        .reset   (reset),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .res_req (res_req),
        .res     (res),
        .res_ack (res_ack)
);

//--- testbench/alu_pipe_stim.txt
# pc instr squashed taken illegal write_rd rd value, all columns in hex
# squashed lines are acked at the input but expect no result
00000100 00500093 0 0 0 1 01 00000005
00000104 ffd00113 0 0 0 1 02 fffffffd
00000108 002081b3 0 0 0 1 03 00000002
0000010c 40208233 0 0 0 1 04 00000008
00000110 001122b3 0 0 0 1 05 00000001
00000114 00113333 0 0 0 1 06 00000000
00000118 0020c3b3 0 0 0 1 07 fffffff8
0000011c 40115413 0 0 0 1 08 fffffffe
00000120 00415493 0 0 0 1 09 0fffffff
00000124 01f09513 0 0 0 1 0a 80000000
00000128 123455b7 0 0 0 1 0b 12345000
0000012c 00001617 0 0 0 1 0c 0000112c
00000130 00708013 0 0 0 1 00 0000000c
00000134 000006b3 0 0 0 1 0d 00000000
00000138 0040e733 0 0 0 1 0e 0000000d
0000013c 7f03f793 0 0 0 1 0f 000007f0
00000140 00108463 0 1 0 0 00 00000148
00000144 06300093 1 0 0 0 00 00000000
00000148 00109463 0 0 0 0 00 0000014c
0000014c 00108813 0 0 0 1 10 00000006
00000150 00114463 0 1 0 0 00 00000158
00000154 03700813 1 0 0 0 00 00000000
00000158 00115463 0 0 0 0 00 0000015c
0000015c 0020e463 0 1 0 0 00 00000164
00000160 04d00093 1 0 0 0 00 00000000
00000164 0020f463 0 0 0 0 00 00000168
00000168 00080893 0 0 0 1 11 00000006
0000016c 000000ff 0 0 1 0 00 00000000
00000170 00008933 0 0 0 1 12 00000005

//--- testbench/result_checker.sv
`timescale 1ns/1ns

module result_checker (
        input  logic            clk,
        input  logic            reset,
        input  logic            res_req,
        input  rv_pkg::result_t res,
        output int              checked,
        output int              errors,
        output logic            all_seen
);
        import rv_pkg::*;

        word_t exp_pc [$];
        word_t exp_tk [$];
        word_t exp_il [$];
        word_t exp_wr [$];
        word_t exp_rd [$];
        word_t exp_val [$];
        int    n_exp = 0;
        int    idx = 0;
        int    err_cnt = 0;
        int    before_cnt;
        logic  req_q = 1'b0;

        assign checked = idx;
        assign errors = err_cnt;
        assign all_seen = (n_exp > 0) && (idx >= n_exp);

        task automatic compare_field(input string name, input word_t exp, input word_t got);
                if (exp !== got) begin
                        $display("[ERROR] %0t ns res.%s expected %h got %h", $time, name, exp, got);
                        err_cnt++;
                end
        endtask

        // ========================================================
        // expected columns, squashed lines dropped
        initial begin
                int    fd;
                int    cnt;
                string line;
                word_t pc, instr, sq, tk, il, wr, rd, val;
                fd = $fopen("testbench/alu_pipe_stim.txt", "r");
                if (fd == 0) begin
                        $display("checker could not open the stimulus file");
                end else begin
                        while ($fgets(line, fd) != 0) begin
                                if (line.len() > 0 && line[0] != "#") begin
                                        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                                      pc, instr, sq, tk, il, wr, rd, val);
                                        if (cnt == 8 && sq == 0) begin
                                                exp_pc.push_back(pc);
                                                exp_tk.push_back(tk);
                                                exp_il.push_back(il);
                                                exp_wr.push_back(wr);
                                                exp_rd.push_back(rd);
                                                exp_val.push_back(val);
                                        end
                                end
                        end
                        $fclose(fd);
                        n_exp = exp_pc.size();
                end
        end

        // ========================================================
        // compare on each rise of res_req
        always @(negedge clk) begin
                req_q <= res_req;
                if (!reset && res_req && !req_q) begin
                        if (idx >= n_exp) begin
                                $display("a result for pc %h arrived with no expected entry left",
                                         res.pc);
                                err_cnt++;
                        end else begin
                                before_cnt = err_cnt;
                                compare_field("pc", exp_pc[idx], res.pc);
                                compare_field("rd", exp_rd[idx], {27'b0, res.rd});
                                compare_field("value", exp_val[idx], res.value);
                                compare_field("write_rd", exp_wr[idx], {31'b0, res.write_rd});
                                compare_field("taken", exp_tk[idx], {31'b0, res.taken});
                                compare_field("illegal", exp_il[idx], {31'b0, res.illegal});
                                if (err_cnt == before_cnt)
                                        $display("result %0d pc %h ok", idx, res.pc);
                                else
                                        $display("result %0d pc %h mismatch", idx, res.pc);
                                idx++;
                        end
                end
        end

endmodule

//--- testbench/tb_alu_pipe.sv
`timescale 1ns/1ns

module tb_alu_pipe;
        import rv_pkg::*;

        localparam string STIM_FILE = "testbench/alu_pipe_stim.txt";
        localparam int CYCLES_PER_LINE = 40;

        logic       clk;
        logic       reset;
        logic       in_req;
        fetch_pkt_t in_pkt;
        logic       in_ack;
        logic       res_req;
        result_t    res;
        logic       res_ack;
        int         checked;
        int         errors;
        logic       all_seen;
        word_t      pcs [$];
        word_t      instrs [$];
        int         n_lines = 0;

        alu_pipe_top i_dut (
                .clk     (clk),
                .reset   (reset),
                .in_req  (in_req),
                .in_pkt  (in_pkt),
                .in_ack  (in_ack),
                .res_req (res_req),
                .res     (res),
                .res_ack (res_ack)
        );

        result_checker i_checker (
                .clk      (clk),
                .reset    (reset),
                .res_req  (res_req),
                .res      (res),
                .checked  (checked),
                .errors   (errors),
                .all_seen (all_seen)
        );

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        // one full four-phase exchange on the input side
        task automatic send_item(input word_t pc, input word_t instr);
                @(negedge clk);
                in_pkt.pc = pc;
                in_pkt.instr = instr;
                in_req = 1'b1;
                while (!in_ack)
                        @(negedge clk);
                in_req = 1'b0;
                while (in_ack)
                        @(negedge clk);
        endtask

        // ========================================================
        // stimulus and final summary
        initial begin
                int    fd;
                int    cnt;
                int    i;
                string line;
                word_t pc, instr, sq, tk, il, wr, rd, val;
                reset = 1'b1;
                in_req = 1'b0;
                in_pkt = '0;
                fd = $fopen(STIM_FILE, "r");
                if (fd == 0) begin
                        $display("could not open the stimulus file %s", STIM_FILE);
                end else begin
                        while ($fgets(line, fd) != 0) begin
                                if (line.len() > 0 && line[0] != "#") begin
                                        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                                      pc, instr, sq, tk, il, wr, rd, val);
                                        if (cnt == 8) begin
                                                pcs.push_back(pc);
                                                instrs.push_back(instr);
                                        end
                                end
                        end
                        $fclose(fd);
                        n_lines = pcs.size();
                end
                repeat (4) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                if (n_lines > 0) begin
                        for (i = 0; i < n_lines; i++)
                                send_item(pcs[i], instrs[i]);
                        while (!all_seen)
                                @(negedge clk);
                end
                // room for any extra result to show up
                repeat (20) @(negedge clk);
                $display("%0d results checked, %0d errors", checked, errors);
                if (errors == 0 && checked > 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

        // sink with random ack delays
        initial begin
                int delay;
                void'($urandom(32'h4812_40be));
                res_ack = 1'b0;
                wait (reset === 1'b0);
                forever begin
                        @(negedge clk);
                        if (res_req) begin
                                delay = $urandom % 6;
                                repeat (delay) @(negedge clk);
                                res_ack = 1'b1;
                                while (res_req)
                                        @(negedge clk);
                                delay = $urandom % 6;
                                repeat (delay) @(negedge clk);
                                res_ack = 1'b0;
                        end
                end
        end

        initial begin
                int limit;
                wait (reset === 1'b0);
                limit = n_lines * CYCLES_PER_LINE;
                repeat (limit) @(posedge clk);
                $display("timeout after %0d cycles, results are still missing", limit);
                $display(">>> FAIL");
                $finish;
        end

endmodule

//--- vlog.f
hw/rv_pkg.sv
hw/inst_decode.sv
hw/id_ex_reg.sv
hw/alu_execute.sv
hw/result_writeback.sv
hw/alu_pipe_top.sv
testbench/alu_pipe_assertions.sv
testbench/result_checker.sv
testbench/tb_alu_pipe.sv
